/* design/isaPkg.sv */
package isaPkg;

    typedef logic [3:0] opcodeT;
    typedef logic [5:0] functT;
    typedef logic [3:0] aluOpT;

    // Primary opcodes
    localparam opcodeT OpBne   = 4'd0;
    localparam opcodeT OpBeq   = 4'd1;
    localparam opcodeT OpBgz   = 4'd2;
    localparam opcodeT OpBlz   = 4'd3;
    localparam opcodeT OpAdi   = 4'd4;
    localparam opcodeT OpOri   = 4'd5;
    localparam opcodeT OpLhi   = 4'd6;
    localparam opcodeT OpLwd   = 4'd7;
    localparam opcodeT OpSwd   = 4'd8;
    localparam opcodeT OpJmp   = 4'd9;
    localparam opcodeT OpJal   = 4'd10;
    localparam opcodeT OpRtype = 4'd15;

    // R-type function field
    localparam functT FnAdd = 6'd0;
    localparam functT FnSub = 6'd1;
    localparam functT FnAnd = 6'd2;
    localparam functT FnOrr = 6'd3;
    localparam functT FnNot = 6'd4;
    localparam functT FnTcp = 6'd5;
    localparam functT FnShl = 6'd6;
    localparam functT FnShr = 6'd7;
    localparam functT FnJpr = 6'd25;
    localparam functT FnJrl = 6'd26;
    localparam functT FnWwd = 6'd28;
    localparam functT FnHlt = 6'd29;

    localparam logic [1:0] FnControlBits = 2'b01; // funct[5:4] of decode-only ops

    localparam aluOpT AluAdd  = 4'd0;
    localparam aluOpT AluSub  = 4'd1;
    localparam aluOpT AluAnd  = 4'd2;
    localparam aluOpT AluOr   = 4'd3;
    localparam aluOpT AluNot  = 4'd4;
    localparam aluOpT AluTcp  = 4'd5; // Two's complement
    localparam aluOpT AluShl  = 4'd6;
    localparam aluOpT AluShr  = 4'd7; // Arithmetic right shift
    localparam aluOpT AluPass = 4'd8; // Immediate to upper half
    localparam aluOpT AluBne  = 4'd9;
    localparam aluOpT AluBeq  = 4'd10;
    localparam aluOpT AluBgz  = 4'd11;
    localparam aluOpT AluBlz  = 4'd12;

endpackage

/* design/controlPkg.sv */
package controlPkg;

    typedef enum logic [2:0] {
        StReset     = 3'b111,
        StFetch     = 3'b000,
        StDecode    = 3'b001,
        StExecute   = 3'b010,
        StMemory    = 3'b110,
        StWriteback = 3'b011
    } stateT;

    typedef enum logic [3:0] {
        ClsAlu,
        ClsImm,     // ADI, ORI, LHI
        ClsLoad,
        ClsStore,
        ClsBranch,
        ClsJump,
        ClsLink,
        ClsRegJump,
        ClsRegLink,
        ClsOutput,
        ClsHalt,
        ClsNop
    } instrClassT;

    typedef logic [1:0] regDstT;
    typedef logic [1:0] srcAT;
    typedef logic [1:0] srcBT;
    typedef logic [1:0] pcSrcT;

    localparam regDstT DstRt   = 2'd0;
    localparam regDstT DstRd   = 2'd1;
    localparam regDstT DstLink = 2'd2; // Link register $2

    localparam srcAT SrcAPc  = 2'd0;
    localparam srcAT SrcAReg = 2'd1;
    localparam srcAT SrcAImm = 2'd2;

    localparam srcBT SrcBReg = 2'd0;
    localparam srcBT SrcBOne = 2'd1;
    localparam srcBT SrcBImm = 2'd2;

    localparam pcSrcT PcAlu    = 2'd0;
    localparam pcSrcT PcJump   = 2'd1;
    localparam pcSrcT PcBranch = 2'd2;
    localparam pcSrcT PcReg    = 2'd3;

endpackage

/* design/instrClassifier.sv */
`timescale 1ns/1ps

module instrClassifier (
    input  isaPkg::opcodeT          opcode,
    input  isaPkg::functT           funct,
    output controlPkg::instrClassT  instrClass,
    output isaPkg::aluOpT           exAluOp
);

    always_comb begin
        instrClass = controlPkg::ClsNop;
        exAluOp    = isaPkg::AluAdd;

        case (opcode)
            isaPkg::OpBne: begin
                instrClass = controlPkg::ClsBranch;
                exAluOp    = isaPkg::AluBne;
            end
            isaPkg::OpBeq: begin
                instrClass = controlPkg::ClsBranch;
                exAluOp    = isaPkg::AluBeq;
            end
            isaPkg::OpBgz: begin
                instrClass = controlPkg::ClsBranch;
                exAluOp    = isaPkg::AluBgz;
            end
            isaPkg::OpBlz: begin
                instrClass = controlPkg::ClsBranch;
                exAluOp    = isaPkg::AluBlz;
            end
            isaPkg::OpAdi: instrClass = controlPkg::ClsImm;
            isaPkg::OpOri: begin
                instrClass = controlPkg::ClsImm;
                exAluOp    = isaPkg::AluOr;
            end
            isaPkg::OpLhi: begin
                instrClass = controlPkg::ClsImm;
                exAluOp    = isaPkg::AluPass;
            end
            isaPkg::OpLwd: instrClass = controlPkg::ClsLoad;
            isaPkg::OpSwd: instrClass = controlPkg::ClsStore;
            isaPkg::OpJmp: instrClass = controlPkg::ClsJump;
            isaPkg::OpJal: instrClass = controlPkg::ClsLink;
            isaPkg::OpRtype: begin
                if (funct[5:4] == isaPkg::FnControlBits) begin // Finishes in decode
                    case (funct)
                        isaPkg::FnJpr: instrClass = controlPkg::ClsRegJump;
                        isaPkg::FnJrl: instrClass = controlPkg::ClsRegLink;
                        isaPkg::FnWwd: instrClass = controlPkg::ClsOutput;
                        isaPkg::FnHlt: instrClass = controlPkg::ClsHalt;
                        default:       instrClass = controlPkg::ClsNop;
                    endcase
                end else begin
                    instrClass = controlPkg::ClsAlu;
                    case (funct)
                        isaPkg::FnAdd: exAluOp = isaPkg::AluAdd;
                        isaPkg::FnSub: exAluOp = isaPkg::AluSub;
                        isaPkg::FnAnd: exAluOp = isaPkg::AluAnd;
                        isaPkg::FnOrr: exAluOp = isaPkg::AluOr;
                        isaPkg::FnNot: exAluOp = isaPkg::AluNot;
                        isaPkg::FnTcp: exAluOp = isaPkg::AluTcp;
                        isaPkg::FnShl: exAluOp = isaPkg::AluShl;
                        isaPkg::FnShr: exAluOp = isaPkg::AluShr;
                        default:       instrClass = controlPkg::ClsNop; // Unused function
                    endcase
                end
            end
            default: instrClass = controlPkg::ClsNop; // Opcodes 11 to 14
        endcase

        if (!$isunknown(opcode)) begin
            assert (!$isunknown(instrClass))
                else $error("instrClass unknown for opcode %0d", opcode);
        end
    end

endmodule

/* design/stateSequencer.sv */
`timescale 1ns/1ps

module stateSequencer (
    input  logic                    clk,
    input  logic                    reset_n,
    input  controlPkg::instrClassT  instrClass,
    output controlPkg::stateT       state
);

    controlPkg::stateT nextState;
    logic              shortInstr;

    // Classes that complete in fetch and decode
    assign shortInstr = (instrClass == controlPkg::ClsJump)
                     || (instrClass == controlPkg::ClsLink)
                     || (instrClass == controlPkg::ClsRegJump)
                     || (instrClass == controlPkg::ClsRegLink)
                     || (instrClass == controlPkg::ClsOutput)
                     || (instrClass == controlPkg::ClsHalt)
                     || (instrClass == controlPkg::ClsNop);

    always_comb begin
        case (state)
            controlPkg::StReset:  nextState = controlPkg::StFetch;
            controlPkg::StFetch:  nextState = controlPkg::StDecode;
            controlPkg::StDecode: begin
                nextState = shortInstr ? controlPkg::StFetch : controlPkg::StExecute;
            end
            controlPkg::StExecute: begin
                if (instrClass == controlPkg::ClsBranch)
                    nextState = controlPkg::StFetch;
                else if (instrClass == controlPkg::ClsLoad || instrClass == controlPkg::ClsStore)
                    nextState = controlPkg::StMemory;
                else
                    nextState = controlPkg::StWriteback;
            end
            controlPkg::StMemory: begin
                nextState = (instrClass == controlPkg::ClsLoad) ? controlPkg::StWriteback
                                                               : controlPkg::StFetch;
            end
            controlPkg::StWriteback: nextState = controlPkg::StFetch;
            default:                 nextState = controlPkg::StReset; // Illegal encoding
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state <= controlPkg::StReset;
        end else begin
            state <= nextState;
        end
    end

    memEntry: assert property (@(posedge clk) disable iff (reset_n)
        (state == controlPkg::StMemory) |->
            ($past(state) == controlPkg::StExecute)
            && ($past(instrClass) == controlPkg::ClsLoad
                || $past(instrClass) == controlPkg::ClsStore));

    // Covers entry from both execute and memory
    noStoreWriteback: assert property (@(posedge clk) disable iff (reset_n)
        (state == controlPkg::StWriteback) |-> (instrClass != controlPkg::ClsStore));

endmodule

/* design/controlSignalGen.sv */
`timescale 1ns/1ps

module controlSignalGen (
    input  controlPkg::stateT       state,
    input  controlPkg::instrClassT  instrClass,
    input  isaPkg::aluOpT           exAluOp,
    output logic                    pcWrite,
    output logic                    pcWriteCond,
    output logic                    iOrD,
    output logic                    memRead,
    output logic                    memWrite,
    output logic                    memToReg,
    output logic                    irWrite,
    output logic                    regWrite,
    output logic                    halted,
    output logic                    wordOut,
    output controlPkg::regDstT      regDst,
    output controlPkg::srcAT        aluSrcA,
    output controlPkg::srcBT        aluSrcB,
    output isaPkg::aluOpT           aluOp,
    output controlPkg::pcSrcT       pcSource
);

    always_comb begin
        pcWrite     = 1'b0;
        pcWriteCond = 1'b0;
        iOrD        = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        memToReg    = 1'b0;
        irWrite     = 1'b0;
        regWrite    = 1'b0;
        halted      = 1'b0;
        wordOut     = 1'b0;
        regDst      = controlPkg::DstRt;
        aluSrcA     = controlPkg::SrcAPc;
        aluSrcB     = controlPkg::SrcBReg;
        aluOp       = isaPkg::AluAdd;
        pcSource    = controlPkg::PcAlu;

        case (state)
            controlPkg::StFetch: begin
                memRead = 1'b1; // Instruction read at PC
                irWrite = 1'b1;
            end
            controlPkg::StDecode: begin
                pcWrite = 1'b1; // PC + 1 unless redirected
                aluSrcA = controlPkg::SrcAPc;
                aluSrcB = controlPkg::SrcBOne;
                aluOp   = isaPkg::AluAdd;
                case (instrClass)
                    controlPkg::ClsJump:    pcSource = controlPkg::PcJump;
                    controlPkg::ClsRegJump: pcSource = controlPkg::PcReg;
                    controlPkg::ClsLink: begin
                        pcSource = controlPkg::PcJump;
                        regWrite = 1'b1;
                        regDst   = controlPkg::DstLink;
                    end
                    controlPkg::ClsRegLink: begin
                        pcSource = controlPkg::PcReg;
                        regWrite = 1'b1;
                        regDst   = controlPkg::DstLink;
                    end
                    controlPkg::ClsHalt:   halted  = 1'b1;
                    controlPkg::ClsOutput: wordOut = 1'b1;
                    default: ;
                endcase
            end
            controlPkg::StExecute: begin
                aluSrcA = (exAluOp == isaPkg::AluPass) ? controlPkg::SrcAImm // LHI
                                                       : controlPkg::SrcAReg;
                aluSrcB = (instrClass == controlPkg::ClsAlu || instrClass == controlPkg::ClsBranch)
                        ? controlPkg::SrcBReg : controlPkg::SrcBImm;
                aluOp   = exAluOp;
                if (instrClass == controlPkg::ClsBranch) begin
                    pcWriteCond = 1'b1;
                    pcSource    = controlPkg::PcBranch;
                end
            end
            controlPkg::StMemory: begin
                iOrD     = 1'b1; // Data address from ALU out
                memRead  = (instrClass == controlPkg::ClsLoad);
                memWrite = (instrClass == controlPkg::ClsStore);
            end
            controlPkg::StWriteback: begin
                regWrite = 1'b1;
                regDst   = (instrClass == controlPkg::ClsAlu) ? controlPkg::DstRd
                                                              : controlPkg::DstRt;
                memToReg = (instrClass == controlPkg::ClsLoad);
            end
            default: ; // Reset state keeps every enable low
        endcase

        assert (!(memRead && memWrite))
            else $error("memRead and memWrite both high in state %0d", state);
    end

endmodule

/* design/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  logic                clk,
    input  logic                reset_n,
    input  isaPkg::opcodeT      opcode,
    input  isaPkg::functT       funct,
    output logic                pcWrite,
    output logic                pcWriteCond,
    output logic                iOrD,
    output logic                memRead,
    output logic                memWrite,
    output logic                memToReg,
    output logic                irWrite,
    output logic                regWrite,
    output logic                halted,
    output logic                wordOut,
    output controlPkg::regDstT  regDst,
    output controlPkg::srcAT    aluSrcA,
    output controlPkg::srcBT    aluSrcB,
    output isaPkg::aluOpT       aluOp,
    output controlPkg::pcSrcT   pcSource,
    output controlPkg::stateT   currentState
);

    controlPkg::instrClassT instrClass;
    isaPkg::aluOpT          exAluOp;

    instrClassifier instrClassifier_inst (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass),
        .exAluOp    (exAluOp)
    );

    stateSequencer stateSequencer_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .instrClass (instrClass),
        .state      (currentState)
    );

    controlSignalGen controlSignalGen_inst (
        .state       (currentState),
        .instrClass  (instrClass),
        .exAluOp     (exAluOp),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .iOrD        (iOrD),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .memToReg    (memToReg),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .halted      (halted),
        .wordOut     (wordOut),
        .regDst      (regDst),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp),
        .pcSource    (pcSource)
    );

endmodule

/* verif/controlUnitTb.sv */
`timescale 1ns/1ps

module controlUnitTb;

    localparam int  NumRandom = 400;
    localparam time ClkPeriod = 8;

    typedef struct packed {
        logic pcWrite, pcWriteCond, iOrD, memRead, memWrite;
        logic memToReg, irWrite, regWrite, halted, wordOut;
        logic [1:0] regDst, aluSrcA, aluSrcB;
        logic [3:0] aluOp;
        logic [1:0] pcSource;
    } ctrlT;

    logic clk;
    logic reset_n;
    isaPkg::opcodeT opcode;
    isaPkg::functT funct;
    logic pcWrite, pcWriteCond, iOrD, memRead, memWrite;
    logic memToReg, irWrite, regWrite, halted, wordOut;
    controlPkg::regDstT regDst;
    controlPkg::srcAT aluSrcA;
    controlPkg::srcBT aluSrcB;
    isaPkg::aluOpT aluOp;
    controlPkg::pcSrcT pcSource;
    controlPkg::stateT currentState;
    controlPkg::stateT expState;
    logic started = 1'b0;
    logic [31:0] lfsr;
    int errorCount = 0;
    int testErrors = 0;
    int testCount = 0;

    controlUnit controlUnit_inst (.*);

    function automatic controlPkg::instrClassT refClass(input isaPkg::opcodeT op,
                                                        input isaPkg::functT fn);
        case (op)
            isaPkg::OpBne, isaPkg::OpBeq, isaPkg::OpBgz, isaPkg::OpBlz: return controlPkg::ClsBranch;
            isaPkg::OpAdi, isaPkg::OpOri, isaPkg::OpLhi: return controlPkg::ClsImm;
            isaPkg::OpLwd: return controlPkg::ClsLoad;
            isaPkg::OpSwd: return controlPkg::ClsStore;
            isaPkg::OpJmp: return controlPkg::ClsJump;
            isaPkg::OpJal: return controlPkg::ClsLink;
            isaPkg::OpRtype: begin
                case (fn)
                    isaPkg::FnJpr: return controlPkg::ClsRegJump;
                    isaPkg::FnJrl: return controlPkg::ClsRegLink;
                    isaPkg::FnWwd: return controlPkg::ClsOutput;
                    isaPkg::FnHlt: return controlPkg::ClsHalt;
                    default: return (fn[5:3] == 3'b000) ? controlPkg::ClsAlu : controlPkg::ClsNop;
                endcase
            end
            default: return controlPkg::ClsNop; // Opcodes 11 to 14
        endcase
    endfunction

    function automatic isaPkg::aluOpT refAluOp(input isaPkg::opcodeT op, input isaPkg::functT fn);
        case (op)
            isaPkg::OpBne: return isaPkg::AluBne;
            isaPkg::OpBeq: return isaPkg::AluBeq;
            isaPkg::OpBgz: return isaPkg::AluBgz;
            isaPkg::OpBlz: return isaPkg::AluBlz;
            isaPkg::OpOri: return isaPkg::AluOr;
            isaPkg::OpLhi: return isaPkg::AluPass;
            // R-type functions 0 to 7 share the ALU encoding
            isaPkg::OpRtype: return (fn[5:3] == 3'b000) ? fn[3:0] : isaPkg::AluAdd;
            default: return isaPkg::AluAdd;
        endcase
    endfunction

    function automatic controlPkg::stateT expectedNext(input controlPkg::stateT st,
                                                      input controlPkg::instrClassT cls);
        case (st)
            controlPkg::StReset: return controlPkg::StFetch;
            controlPkg::StFetch: return controlPkg::StDecode;
            controlPkg::StDecode: return (cls inside {controlPkg::ClsAlu, controlPkg::ClsImm,
                controlPkg::ClsLoad, controlPkg::ClsStore, controlPkg::ClsBranch})
                ? controlPkg::StExecute : controlPkg::StFetch;
            controlPkg::StExecute: begin
                if (cls == controlPkg::ClsBranch) return controlPkg::StFetch;
                if (cls inside {controlPkg::ClsLoad, controlPkg::ClsStore}) return controlPkg::StMemory;
                return controlPkg::StWriteback;
            end
            controlPkg::StMemory: return (cls == controlPkg::ClsLoad) ? controlPkg::StWriteback
                                                                     : controlPkg::StFetch;
            default: return controlPkg::StFetch;
        endcase
    endfunction

    function automatic int classLength(input controlPkg::instrClassT cls);
        case (cls)
            controlPkg::ClsBranch: return 3;
            controlPkg::ClsAlu, controlPkg::ClsImm, controlPkg::ClsStore: return 4;
            controlPkg::ClsLoad: return 5;
            default: return 2;
        endcase
    endfunction

    function automatic ctrlT expectedControls(input controlPkg::stateT st,
                                              input isaPkg::opcodeT op, input isaPkg::functT fn);
        ctrlT c;
        controlPkg::instrClassT cls;
        cls = refClass(op, fn);
        c = '0; // Zero selects are PC, Reg, Add, Alu, Rt
        case (st)
            controlPkg::StFetch: begin
                c.memRead = 1'b1;
                c.irWrite = 1'b1;
            end
            controlPkg::StDecode: begin
                c.pcWrite = 1'b1;
                c.aluSrcB = controlPkg::SrcBOne;
                if (cls inside {controlPkg::ClsJump, controlPkg::ClsLink}) c.pcSource = controlPkg::PcJump;
                if (cls inside {controlPkg::ClsRegJump, controlPkg::ClsRegLink}) c.pcSource = controlPkg::PcReg;
                c.regWrite = (cls inside {controlPkg::ClsLink, controlPkg::ClsRegLink});
                c.regDst = c.regWrite ? controlPkg::DstLink : controlPkg::DstRt;
                c.halted = (cls == controlPkg::ClsHalt);
                c.wordOut = (cls == controlPkg::ClsOutput);
            end
            controlPkg::StExecute: begin
                c.aluSrcA = (op == isaPkg::OpLhi) ? controlPkg::SrcAImm : controlPkg::SrcAReg;
                c.aluSrcB = (cls inside {controlPkg::ClsAlu, controlPkg::ClsBranch})
                          ? controlPkg::SrcBReg : controlPkg::SrcBImm;
                c.aluOp = refAluOp(op, fn);
                c.pcWriteCond = (cls == controlPkg::ClsBranch);
                c.pcSource = c.pcWriteCond ? controlPkg::PcBranch : controlPkg::PcAlu;
            end
            controlPkg::StMemory: begin
                c.iOrD = 1'b1;
                c.memRead = (cls == controlPkg::ClsLoad);
                c.memWrite = (cls == controlPkg::ClsStore);
            end
            controlPkg::StWriteback: begin
                c.regWrite = 1'b1;
                c.regDst = (cls == controlPkg::ClsAlu) ? controlPkg::DstRd : controlPkg::DstRt;
                c.memToReg = (cls == controlPkg::ClsLoad);
            end
            default: ;
        endcase
        return c;
    endfunction

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic drawBits(input int n, output logic [31:0] val);
        val = '0;
        repeat (n) begin
            lfsr = lfsrStep(lfsr);
            val = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic compareField(input string name, input logic [3:0] expected,
                                input logic [3:0] actual);
        if (expected !== actual) begin
            $display("error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic endTest(input string name);
        $display("test %s: %0d errors", name, errorCount - testErrors);
        testErrors = errorCount;
        testCount++;
    endtask

    // Presents one instruction at the edge into fetch, returns in its last cycle
    task automatic runInstr(input isaPkg::opcodeT op, input isaPkg::functT fn);
        int len;
        controlPkg::instrClassT cls;
        cls = refClass(op, fn);
        len = 0;
        @(posedge clk);
        opcode <= op;
        funct <= fn;
        do begin
            @(negedge clk);
            len++;
            if ((halted || wordOut) && currentState != controlPkg::StDecode) begin
                $display("error at %0t: halted or wordOut high outside decode", $time);
                errorCount++;
            end
        end while (expectedNext(currentState, cls) != controlPkg::StFetch && len < 8);
        if (len != classLength(cls)) begin
            $display("error at %0t: instruction length expected %0d got %0d", $time,
                     classLength(cls), len);
            errorCount++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        expState <= reset_n ? controlPkg::StReset : expectedNext(expState, refClass(opcode, funct));
        started <= 1'b1;
    end

    always @(negedge clk) begin
        ctrlT e;
        if (started) begin
            e = expectedControls(expState, opcode, funct);
            compareField("currentState", 4'(expState), 4'(currentState));
            compareField("pcWrite", 4'(e.pcWrite), 4'(pcWrite));
            compareField("pcWriteCond", 4'(e.pcWriteCond), 4'(pcWriteCond));
            compareField("iOrD", 4'(e.iOrD), 4'(iOrD));
            compareField("memRead", 4'(e.memRead), 4'(memRead));
            compareField("memWrite", 4'(e.memWrite), 4'(memWrite));
            compareField("memToReg", 4'(e.memToReg), 4'(memToReg));
            compareField("irWrite", 4'(e.irWrite), 4'(irWrite));
            compareField("regWrite", 4'(e.regWrite), 4'(regWrite));
            compareField("halted", 4'(e.halted), 4'(halted));
            compareField("wordOut", 4'(e.wordOut), 4'(wordOut));
            compareField("regDst", 4'(e.regDst), 4'(regDst));
            compareField("aluSrcA", 4'(e.aluSrcA), 4'(aluSrcA));
            compareField("aluSrcB", 4'(e.aluSrcB), 4'(aluSrcB));
            compareField("aluOp", e.aluOp, aluOp);
            compareField("pcSource", 4'(e.pcSource), 4'(pcSource));
        end
    end

    initial begin
        #(2 * NumRandom * 5 * ClkPeriod); // Longest instruction, twice over
        $display("Timeout: the run did not reach its end in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        isaPkg::functT controlFns [4];
        logic [31:0] bits;
        isaPkg::opcodeT op;
        isaPkg::functT fn;
        controlFns = '{isaPkg::FnJpr, isaPkg::FnJrl, isaPkg::FnWwd, isaPkg::FnHlt};
        lfsr = 32'hb81a_4a69;
        reset_n = 1'b1;
        opcode = '0;
        funct = '0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b0;
        @(negedge clk);
        if (currentState !== controlPkg::StReset) begin
            $display("error at %0t: currentState expected %0h got %0h", $time,
                     controlPkg::StReset, currentState);
            errorCount++;
        end
        endTest("reset");

        runInstr(isaPkg::OpLwd, '0);
        runInstr(isaPkg::OpSwd, '0);
        endTest("load and store");

        runInstr(isaPkg::OpRtype, isaPkg::FnWwd);
        runInstr(isaPkg::OpRtype, isaPkg::FnHlt);
        runInstr(isaPkg::OpJal, '0);
        runInstr(isaPkg::OpRtype, isaPkg::FnJrl);
        endTest("output, halt and links");

        for (int f = 0; f < 8; f++) runInstr(isaPkg::OpRtype, 6'(f));
        for (int o = 0; o < 7; o++) runInstr(4'(o), '0);
        for (int o = 11; o < 15; o++) runInstr(4'(o), '0);
        endTest("ALU operation mapping");

        for (int i = 0; i < NumRandom; i++) begin
            drawBits(4, bits);
            op = bits[3:0];
            drawBits(6, bits);
            fn = bits[5:0];
            if (op == isaPkg::OpRtype) begin
                drawBits(2, bits);
                if (bits[1:0] == 2'd0) begin // Force a control function
                    drawBits(2, bits);
                    fn = controlFns[bits[1:0]];
                end
            end
            runInstr(op, fn);
        end
        endTest("random sequencing and controls");

        @(posedge clk);
        $display("%0d tests, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* tb.f */
design/isaPkg.sv
design/controlPkg.sv
design/instrClassifier.sv
design/stateSequencer.sv
design/controlSignalGen.sv
design/controlUnit.sv
verif/controlUnitTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module controlUnitTb -o controlUnitSim

output=$(./obj_dir/controlUnitSim)
echo "$output"

# Exit status of grep decides pass or fail
echo "$output" | grep -qx "All checks passed"
